//--- verilog/axil_regs_pkg.sv
package axil_regs_pkg;

  // Bus geometry.
  localparam int DATA_W    = 32;
  localparam int BYTE_W    = 8;
  localparam int STRB_W    = DATA_W / BYTE_W;  // One strobe bit per byte lane.
  localparam int ADDR_W    = 7;
  localparam int ADDR_LSB  = 2;                // Byte offset below the word index.
  localparam int REG_IDX_W = ADDR_W - ADDR_LSB;
  localparam int NUM_REGS  = 1 << REG_IDX_W;

  // AXI response codes. Only OKAY is ever returned.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_t;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // One strobed write into the bank.
  typedef struct packed {
    reg_idx_t          idx;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } wr_req_t;

  // Read data beat as presented on the R channel.
  typedef struct packed {
    logic [DATA_W-1:0] data;
    axi_resp_t         resp;
  } rd_rsp_t;

endpackage

//--- verilog/axil_resp_slot.sv
`timescale 1ns/1ns

module axil_resp_slot import axil_regs_pkg::*; #(
  parameter type payload_t = axi_resp_t
) (
  input  logic     S_AXI_ACLK,
  input  logic     S_AXI_ARESETN,
  input  logic     load,
  input  payload_t payload_in,
  input  logic     ready,
  output logic     valid,
  output payload_t payload_out
);

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;          // A new response wins over a drain.
    end else if (valid && ready) begin
      valid <= 1'b0;
    end
  end

  // Only written on load, so it holds while the master stalls.
  always_ff @(posedge S_AXI_ACLK) begin
    if (load) begin
      payload_out <= payload_in;
    end
  end

endmodule

//--- verilog/axil_reg_bank.sv
`timescale 1ns/1ns

module axil_reg_bank import axil_regs_pkg::*; (
  input  logic              S_AXI_ACLK,
  input  logic              S_AXI_ARESETN,
  input  logic              wr_en,
  input  wr_req_t           wr_req,
  input  reg_idx_t          rd_idx,
  output logic [DATA_W-1:0] rd_data
);

  logic [DATA_W-1:0] regs [NUM_REGS];

  // Take new bytes where the strobe is set, keep the old ones elsewhere.
  function automatic logic [DATA_W-1:0] merge_bytes(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [STRB_W-1:0] strb
  );
    logic [DATA_W-1:0] merged;
    merged = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        merged[b*BYTE_W +: BYTE_W] = new_word[b*BYTE_W +: BYTE_W];
      end
    end
    return merged;
  endfunction

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_req.idx] <= merge_bytes(regs[wr_req.idx], wr_req.data, wr_req.strb);
    end
  end

  // Full 5-bit decode, every index is a real register.
  assign rd_data = regs[rd_idx];

endmodule

//--- verilog/axil_chan_ctrl.sv
`timescale 1ns/1ns

module axil_chan_ctrl import axil_regs_pkg::*; (
  input  logic              S_AXI_ACLK,
  input  logic              S_AXI_ARESETN,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [DATA_W-1:0] wdata,
  input  logic [STRB_W-1:0] wstrb,
  input  logic              wvalid,
  output logic              wready,
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  input  logic              b_valid,
  input  logic              bready,
  input  logic              r_valid,
  input  logic              rready,
  output logic              wr_en,
  output wr_req_t           wr_req,
  output reg_idx_t          rd_idx,
  output logic              b_load,
  output logic              r_load
);

  typedef enum logic {
    WR_IDLE,
    WR_ACCEPT
  } wr_state_t;

  wr_state_t wr_state;
  wr_state_t wr_state_nxt;
  logic      wr_pair;
  logic      wr_hs;
  logic      b_free;
  logic      r_free;
  logic      ar_take;
  logic      ar_hs;

  assign wr_pair = awvalid && wvalid;     // Address and data offered together.
  assign b_free  = !b_valid || bready;    // B slot empty or draining now.
  assign r_free  = !r_valid || rready;

  // Write path.
  always_comb begin
    wr_state_nxt = wr_state;
    case (wr_state)
      WR_IDLE: begin
        if (wr_pair && b_free) begin
          wr_state_nxt = WR_ACCEPT;
        end
      end
      WR_ACCEPT: begin
        wr_state_nxt = WR_IDLE;           // Readies are a single-cycle pulse.
      end
    endcase
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_state <= WR_IDLE;
    end else begin
      wr_state <= wr_state_nxt;
    end
  end

  assign awready = (wr_state == WR_ACCEPT);
  assign wready  = (wr_state == WR_ACCEPT);
  assign wr_hs   = awready && wr_pair;

  // Bank write and B response land on the handshake edge.
  assign wr_en  = wr_hs;
  assign b_load = wr_hs;

  always_comb begin
    wr_req.idx  = awaddr[ADDR_LSB +: REG_IDX_W];
    wr_req.data = wdata;
    wr_req.strb = wstrb;
  end

  // Read path.
  assign ar_take = !arready && arvalid && r_free;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      arready <= 1'b0;
    end else begin
      arready <= ar_take;
    end
  end

  // Index is latched as ARREADY rises so the bank output settles during the pulse.
  always_ff @(posedge S_AXI_ACLK) begin
    if (ar_take) begin
      rd_idx <= araddr[ADDR_LSB +: REG_IDX_W];
    end
  end

  assign ar_hs  = arready && arvalid;
  assign r_load = ar_hs;                  // RDATA is sampled only here.

endmodule

//--- verilog/axil_regs.sv
`timescale 1ns/1ns

module axil_regs import axil_regs_pkg::*; (
  input  logic              S_AXI_ACLK,
  input  logic              S_AXI_ARESETN,
  // Write address.
  input  logic [ADDR_W-1:0] S_AXI_AWADDR,
  input  logic              S_AXI_AWVALID,
  output logic              S_AXI_AWREADY,
  // Write data.
  input  logic [DATA_W-1:0] S_AXI_WDATA,
  input  logic [STRB_W-1:0] S_AXI_WSTRB,
  input  logic              S_AXI_WVALID,
  output logic              S_AXI_WREADY,
  // Write response.
  output logic [1:0]        S_AXI_BRESP,
  output logic              S_AXI_BVALID,
  input  logic              S_AXI_BREADY,
  // Read address.
  input  logic [ADDR_W-1:0] S_AXI_ARADDR,
  input  logic              S_AXI_ARVALID,
  output logic              S_AXI_ARREADY,
  // Read data.
  output logic [DATA_W-1:0] S_AXI_RDATA,
  output logic [1:0]        S_AXI_RRESP,
  output logic              S_AXI_RVALID,
  input  logic              S_AXI_RREADY
);

  logic              wr_en;
  wr_req_t           wr_req;
  reg_idx_t          rd_idx;
  logic [DATA_W-1:0] rd_data;
  logic              b_load;
  logic              r_load;
  axi_resp_t         b_resp;
  rd_rsp_t           r_payload;
  rd_rsp_t           r_out;

  axil_chan_ctrl ctrl_i (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (S_AXI_AWADDR),
    .awvalid       (S_AXI_AWVALID),
    .awready       (S_AXI_AWREADY),
    .wdata         (S_AXI_WDATA),
    .wstrb         (S_AXI_WSTRB),
    .wvalid        (S_AXI_WVALID),
    .wready        (S_AXI_WREADY),
    .araddr        (S_AXI_ARADDR),
    .arvalid       (S_AXI_ARVALID),
    .arready       (S_AXI_ARREADY),
    .b_valid       (S_AXI_BVALID),
    .bready        (S_AXI_BREADY),
    .r_valid       (S_AXI_RVALID),
    .rready        (S_AXI_RREADY),
    .wr_en         (wr_en),
    .wr_req        (wr_req),
    .rd_idx        (rd_idx),
    .b_load        (b_load),
    .r_load        (r_load)
  );

  axil_reg_bank bank_i (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_en         (wr_en),
    .wr_req        (wr_req),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data)
  );

  axil_resp_slot #(.payload_t(axi_resp_t)) b_slot (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .load          (b_load),
    .payload_in    (RESP_OKAY),
    .ready         (S_AXI_BREADY),
    .valid         (S_AXI_BVALID),
    .payload_out   (b_resp)
  );

  assign r_payload = '{data: rd_data, resp: RESP_OKAY};

  axil_resp_slot #(.payload_t(rd_rsp_t)) r_slot (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .load          (r_load),
    .payload_in    (r_payload),
    .ready         (S_AXI_RREADY),
    .valid         (S_AXI_RVALID),
    .payload_out   (r_out)
  );

  assign S_AXI_BRESP = b_resp;
  assign S_AXI_RDATA = r_out.data;
  assign S_AXI_RRESP = r_out.resp;

endmodule

//--- tests/axil_regs_properties.sv
`timescale 1ns/1ns

module axil_regs_properties import axil_regs_pkg::*; (
  input logic              S_AXI_ACLK,
  input logic              S_AXI_ARESETN,
  input logic              S_AXI_AWREADY,
  input logic              S_AXI_WREADY,
  input logic              S_AXI_BVALID,
  input logic              S_AXI_BREADY,
  input logic              S_AXI_RVALID,
  input logic              S_AXI_RREADY,
  input logic [DATA_W-1:0] S_AXI_RDATA
);

  int failures = 0;

  ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_AWREADY == S_AXI_WREADY)
    else begin
      $error("AWREADY and WREADY differ");
      failures++;
    end

  b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID && !S_AXI_AWREADY)
    else begin
      $error("BVALID dropped without BREADY, or a write was taken while B was pending");
      failures++;
    end

  r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA))
    else begin
      $error("RVALID or RDATA changed while RREADY was low");
      failures++;
    end

  reset_idle: assert property (@(posedge S_AXI_ACLK)
    !S_AXI_ARESETN |=> !S_AXI_BVALID && !S_AXI_RVALID)
    else begin
      $error("Response valid high right after reset");
      failures++;
    end

endmodule

bind axil_regs axil_regs_properties props_i (
  .S_AXI_ACLK    (S_AXI_ACLK),
  .S_AXI_ARESETN (S_AXI_ARESETN),
  .S_AXI_AWREADY (S_AXI_AWREADY),
  .S_AXI_WREADY  (S_AXI_WREADY),
  .S_AXI_BVALID  (S_AXI_BVALID),
  .S_AXI_BREADY  (S_AXI_BREADY),
  .S_AXI_RVALID  (S_AXI_RVALID),
  .S_AXI_RREADY  (S_AXI_RREADY),
  .S_AXI_RDATA   (S_AXI_RDATA)
);

//--- tests/axil_regs_tb.sv
`timescale 1ns/1ns

module axil_regs_tb import axil_regs_pkg::*; ();

  localparam int          VEC_WORDS     = 5;  // Op, address, data, strobe, expected.
  localparam int          MAX_VECS      = 128;
  localparam logic [31:0] VEC_END       = 32'hffff_ffff;
  localparam logic [31:0] OP_READ       = 32'd0;
  localparam logic [31:0] OP_WRITE      = 32'd1;
  localparam logic [31:0] OP_WRITE_READ = 32'd3;

  logic              S_AXI_ACLK;
  logic              S_AXI_ARESETN;
  logic [ADDR_W-1:0] S_AXI_AWADDR;
  logic              S_AXI_AWVALID;
  logic              S_AXI_AWREADY;
  logic [DATA_W-1:0] S_AXI_WDATA;
  logic [STRB_W-1:0] S_AXI_WSTRB;
  logic              S_AXI_WVALID;
  logic              S_AXI_WREADY;
  logic [1:0]        S_AXI_BRESP;
  logic              S_AXI_BVALID;
  logic              S_AXI_BREADY;
  logic [ADDR_W-1:0] S_AXI_ARADDR;
  logic              S_AXI_ARVALID;
  logic              S_AXI_ARREADY;
  logic [DATA_W-1:0] S_AXI_RDATA;
  logic [1:0]        S_AXI_RRESP;
  logic              S_AXI_RVALID;
  logic              S_AXI_RREADY;

  logic [31:0] vec_mem [VEC_WORDS*MAX_VECS];
  int          num_vecs    = 0;
  int          cycle_limit = 100;
  int          cycle_count = 0;
  int          err_count   = 0;
  int          pass_count  = 0;
  int          fail_count  = 0;
  int          b_expected  = 0;
  int          b_seen      = 0;

  axil_regs axil_regs_i (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWADDR  (S_AXI_AWADDR),
    .S_AXI_AWVALID (S_AXI_AWVALID),
    .S_AXI_AWREADY (S_AXI_AWREADY),
    .S_AXI_WDATA   (S_AXI_WDATA),
    .S_AXI_WSTRB   (S_AXI_WSTRB),
    .S_AXI_WVALID  (S_AXI_WVALID),
    .S_AXI_WREADY  (S_AXI_WREADY),
    .S_AXI_BRESP   (S_AXI_BRESP),
    .S_AXI_BVALID  (S_AXI_BVALID),
    .S_AXI_BREADY  (S_AXI_BREADY),
    .S_AXI_ARADDR  (S_AXI_ARADDR),
    .S_AXI_ARVALID (S_AXI_ARVALID),
    .S_AXI_ARREADY (S_AXI_ARREADY),
    .S_AXI_RDATA   (S_AXI_RDATA),
    .S_AXI_RRESP   (S_AXI_RRESP),
    .S_AXI_RVALID  (S_AXI_RVALID),
    .S_AXI_RREADY  (S_AXI_RREADY)
  );

  initial S_AXI_ACLK = 1'b0;
  always #4 S_AXI_ACLK = ~S_AXI_ACLK;

  always @(posedge S_AXI_ACLK) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Run timed out after %0d cycles without finishing the vectors", cycle_count);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  // Address and data go out together and drop after the handshake edge.
  task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb);
    S_AXI_AWADDR  = addr;
    S_AXI_WDATA   = data;
    S_AXI_WSTRB   = strb;
    S_AXI_AWVALID = 1'b1;
    S_AXI_WVALID  = 1'b1;
    @(negedge S_AXI_ACLK);
    while (!S_AXI_AWREADY) @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    S_AXI_AWVALID = 1'b0;
    S_AXI_WVALID  = 1'b0;
    b_expected++;
  endtask

  task automatic read_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
    int unsigned gap;
    S_AXI_ARADDR  = addr;
    S_AXI_ARVALID = 1'b1;
    @(negedge S_AXI_ACLK);
    while (!S_AXI_ARREADY) @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    S_AXI_ARVALID = 1'b0;
    while (!S_AXI_RVALID) @(negedge S_AXI_ACLK);
    gap = $urandom_range(3, 0);
    repeat (gap) @(negedge S_AXI_ACLK);   // Data must hold while stalled.
    check_value("S_AXI_RDATA", S_AXI_RDATA, exp);
    check_value("S_AXI_RRESP", 32'(S_AXI_RRESP), 32'(RESP_OKAY));
    S_AXI_RREADY = 1'b1;
    @(negedge S_AXI_ACLK);
    S_AXI_RREADY = 1'b0;
  endtask

  // Drains write responses on its own, so the next write can meet a full B slot.
  initial begin : b_responder
    int unsigned gap;
    forever begin
      @(negedge S_AXI_ACLK);
      if (S_AXI_BVALID) begin
        gap = $urandom_range(3, 0);
        repeat (gap) @(negedge S_AXI_ACLK);
        check_value("S_AXI_BRESP", 32'(S_AXI_BRESP), 32'(RESP_OKAY));
        S_AXI_BREADY = 1'b1;
        @(negedge S_AXI_ACLK);
        S_AXI_BREADY = 1'b0;
        b_seen++;
      end
    end
  end

  initial begin : main
    logic [31:0] op;
    int          base;
    int          errs_before;
    int          assert_fails;
    void'($urandom(32'hca1b_33cf));
    S_AXI_ARESETN = 1'b0;
    S_AXI_AWADDR  = '0;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WDATA   = '0;
    S_AXI_WSTRB   = '0;
    S_AXI_WVALID  = 1'b0;
    S_AXI_BREADY  = 1'b0;
    S_AXI_ARADDR  = '0;
    S_AXI_ARVALID = 1'b0;
    S_AXI_RREADY  = 1'b0;
    for (int i = 0; i < VEC_WORDS * MAX_VECS; i++) begin
      vec_mem[i] = VEC_END;
    end
    $readmemh("tests/axil_regs_vectors.hex", vec_mem);
    while (num_vecs < MAX_VECS && vec_mem[num_vecs * VEC_WORDS] != VEC_END) begin
      num_vecs++;
    end
    cycle_limit = num_vecs * 20 + 100;
    repeat (5) @(negedge S_AXI_ACLK);
    S_AXI_ARESETN = 1'b1;
    if (num_vecs == 0) begin
      $display("No vectors could be read from the vector file");
      fail_count++;
    end
    for (int v = 0; v < num_vecs; v++) begin
      base        = v * VEC_WORDS;
      op          = vec_mem[base];
      errs_before = err_count;
      case (op)
        OP_READ: read_word(vec_mem[base + 1][ADDR_W-1:0], vec_mem[base + 4]);
        OP_WRITE: write_word(vec_mem[base + 1][ADDR_W-1:0], vec_mem[base + 2],
                             vec_mem[base + 3][STRB_W-1:0]);
        OP_WRITE_READ: begin
          write_word(vec_mem[base + 1][ADDR_W-1:0], vec_mem[base + 2],
                     vec_mem[base + 3][STRB_W-1:0]);
          read_word(vec_mem[base + 1][ADDR_W-1:0], vec_mem[base + 4]);
        end
        default: begin
          $display("Vector %0d has an unknown operation code %h", v, op);
          err_count++;
        end
      endcase
      if (err_count == errs_before) begin
        pass_count++;
        $display("vector %0d op %0d addr %h: ok", v, op, vec_mem[base + 1]);
      end else begin
        fail_count++;
        $display("vector %0d op %0d addr %h: mismatch", v, op, vec_mem[base + 1]);
      end
    end
    errs_before = err_count;
    while (S_AXI_BVALID || S_AXI_BREADY) @(negedge S_AXI_ACLK);
    if (err_count != errs_before) begin
      $display("A write response after the last vector did not match");
      fail_count++;
    end
    if (b_seen != b_expected) begin
      $display("Saw %0d write responses for %0d writes", b_seen, b_expected);
      fail_count++;
    end
    assert_fails = axil_regs_i.props_i.failures;
    if (assert_fails != 0) begin
      $display("Protocol assertions failed %0d times", assert_fails);
      fail_count++;
    end
    $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- tests/axil_regs_vectors.hex
// Columns: op, byte address, write data, write strobe, expected read data.
// Op 0 reads, op 1 writes, op 3 writes and then reads the same address back.
// Every register reads zero after reset.
0 00 00000000 0 00000000
0 04 00000000 0 00000000
0 08 00000000 0 00000000
0 0c 00000000 0 00000000
0 10 00000000 0 00000000
0 14 00000000 0 00000000
0 18 00000000 0 00000000
0 1c 00000000 0 00000000
0 20 00000000 0 00000000
0 24 00000000 0 00000000
0 28 00000000 0 00000000
0 2c 00000000 0 00000000
0 30 00000000 0 00000000
0 34 00000000 0 00000000
0 38 00000000 0 00000000
0 3c 00000000 0 00000000
0 40 00000000 0 00000000
0 44 00000000 0 00000000
0 48 00000000 0 00000000
0 4c 00000000 0 00000000
0 50 00000000 0 00000000
0 54 00000000 0 00000000
0 58 00000000 0 00000000
0 5c 00000000 0 00000000
0 60 00000000 0 00000000
0 64 00000000 0 00000000
0 68 00000000 0 00000000
0 6c 00000000 0 00000000
0 70 00000000 0 00000000
0 74 00000000 0 00000000
0 78 00000000 0 00000000
0 7c 00000000 0 00000000
// Full-strobe write and read back, a distinct value per register.
3 00 01010101 f 01010101
3 04 02020202 f 02020202
3 08 03030303 f 03030303
3 0c 04040404 f 04040404
3 10 05050505 f 05050505
3 14 06060606 f 06060606
3 18 07070707 f 07070707
3 1c 08080808 f 08080808
3 20 09090909 f 09090909
3 24 0a0a0a0a f 0a0a0a0a
3 28 0b0b0b0b f 0b0b0b0b
3 2c 0c0c0c0c f 0c0c0c0c
3 30 0d0d0d0d f 0d0d0d0d
3 34 0e0e0e0e f 0e0e0e0e
3 38 0f0f0f0f f 0f0f0f0f
3 3c 10101010 f 10101010
3 40 11111111 f 11111111
3 44 12121212 f 12121212
3 48 13131313 f 13131313
3 4c 14141414 f 14141414
3 50 15151515 f 15151515
3 54 16161616 f 16161616
3 58 17171717 f 17171717
3 5c 18181818 f 18181818
3 60 19191919 f 19191919
3 64 1a1a1a1a f 1a1a1a1a
3 68 1b1b1b1b f 1b1b1b1b
3 6c 1c1c1c1c f 1c1c1c1c
3 70 1d1d1d1d f 1d1d1d1d
3 74 1e1e1e1e f 1e1e1e1e
3 78 1f1f1f1f f 1f1f1f1f
3 7c 20202020 f 20202020
// Partial strobes keep the old bytes where the strobe bit is clear.
3 00 11223344 f 11223344
3 00 aabbccdd 1 112233dd
3 00 aabbccdd 4 11bb33dd
3 00 55667788 a 55bb77dd
3 7c deadbeef 0 20202020
3 7c deadbeef c dead2020
3 04 0000ff00 2 0202ff02
// Byte offset bits are ignored on both channels.
1 41 13579bdf f 00000000
0 43 00000000 0 13579bdf
0 40 00000000 0 13579bdf
1 22 2468ace0 3 00000000
0 21 00000000 0 0909ace0
3 7f 0f0f0f0f 3 dead0f0f
// Back-to-back writes meet a pending write response.
1 08 01234567 f 00000000
1 0c 89abcdef f 00000000
1 10 fedcba98 f 00000000
1 10 11223344 5 00000000
0 08 00000000 0 01234567
0 0c 00000000 0 89abcdef
0 10 00000000 0 fe22ba44

//--- sources.f
verilog/axil_regs_pkg.sv
verilog/axil_resp_slot.sv
verilog/axil_reg_bank.sv
verilog/axil_chan_ctrl.sv
verilog/axil_regs.sv
tests/axil_regs_properties.sv
tests/axil_regs_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module axil_regs_tb --Mdir obj_dir -o axil_regs_sim -f sources.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/axil_regs_sim +verilator+error+limit+1000 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Test OK" <<< "$sim_out"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation did not report a pass"
exit 1
